// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module quiz_tb -f quiz_top.f -Mdir obj_dir -o quiz_sim

run: compile
	./obj_dir/quiz_sim | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/answer_check.sv ====
`timescale 1ns/1ps

module answer_check (
  input  logic              CLK,
  input  logic              RST,
  // one-cycle launch from control
  input  logic              check_en,
  input  quiz_pkg::answer_t ans,
  input  quiz_pkg::answer_t key,
  output quiz_pkg::result_t result,
  output logic              result_valid
);

  // captured answer and key
  quiz_pkg::answer_t ans_q;
  quiz_pkg::answer_t key_q;
  // capture done, compare next cycle
  logic              check_q;
  // compare terms on the captured pair
  logic              is_blank;
  logic              is_match;

  // all-zero entry counts as no answer
  assign is_blank = (ans_q.d2 == '0) && (ans_q.d1 == '0) && (ans_q.d0 == '0);

  // every digit must agree, one wrong digit fails
  assign is_match = (ans_q.d2 == key_q.d2) &&
                    (ans_q.d1 == key_q.d1) &&
                    (ans_q.d0 == key_q.d0);

  // capture stage
  always_ff @(posedge CLK) begin
    if (check_en) begin
      ans_q <= ans;
      key_q <= key;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      check_q <= 1'b0;
    end else begin
      check_q <= check_en;
    end
  end

  // compare stage
  // exactly one flag while result_valid is high, all low otherwise
  always_ff @(posedge CLK) begin
    if (RST) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= check_q;
      if (check_q) begin
        result.blank   <= is_blank;
        result.correct <= !is_blank && is_match;
        result.wrong   <= !is_blank && !is_match;
      end else begin
        result <= '0;
      end
    end
  end

endmodule

// ==== logic/answer_entry.sv ====
`timescale 1ns/1ps

module answer_entry (
  input  logic                         CLK,
  input  logic                         RST,
  // keys only taken while control holds this high
  input  logic                         entry_open,
  // empties digits and count
  input  logic                         entry_clear,
  // keypad strobe and its digit
  input  logic                         key_strobe,
  input  logic [quiz_pkg::DIGIT_W-1:0] key_digit,
  output quiz_pkg::answer_t            ans,
  output logic                         ans_full
);

  // digits taken so far, stops at three
  logic [quiz_pkg::DCNT_W-1:0] dig_cnt;
  // digit accepted this cycle
  logic                        take_digit;

  // full once the third digit is in
  assign ans_full = (dig_cnt == quiz_pkg::DIGITS_FULL);

  // fourth and later digits dropped
  // keys outside entry dropped too
  assign take_digit = entry_open && key_strobe && !ans_full;

  always_ff @(posedge CLK) begin
    if (RST) begin
      ans     <= '0;
      dig_cnt <= '0;
    end else if (entry_clear) begin
      // clear wins over a key in the same cycle
      ans     <= '0;
      dig_cnt <= '0;
    end else if (take_digit) begin
      // shift left, new digit lands in d0
      // after three keys the first one sits in d2
      ans.d2  <= ans.d1;
      ans.d1  <= ans.d0;
      ans.d0  <= key_digit;
      dig_cnt <= dig_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/question_bank.sv ====
`timescale 1ns/1ps

module question_bank (
  input  logic                         CLK,
  // write port, used from outside while the game is idle
  input  logic                         load_en,
  input  logic [quiz_pkg::QADDR_W-1:0] load_addr,
  input  quiz_pkg::question_t          load_data,
  // read port driven by the control block
  input  logic [quiz_pkg::QADDR_W-1:0] rd_addr,
  output quiz_pkg::question_t          q_word
);

  // question store, one word per question
  // contents only change through the load port
  quiz_pkg::question_t mem [quiz_pkg::NUM_QUESTIONS];

  // synchronous write
  always_ff @(posedge CLK) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // registered read
  // word shows up one cycle after rd_addr
  // read during a write to the same slot returns the old word
  always_ff @(posedge CLK) begin
    q_word <= mem[rd_addr];
  end

endmodule

// ==== logic/quiz_control.sv ====
`timescale 1ns/1ps

module quiz_control (
  input  logic                         CLK,
  input  logic                         RST,
  // game start pulse, honoured in IDLE and DONE
  input  logic                         start,
  // judgement request, honoured in ENTRY only
  input  logic                         submit,
  input  logic                         ans_full,
  // judgement back from the checker
  input  quiz_pkg::result_t            result,
  input  logic                         result_valid,
  output logic [quiz_pkg::QADDR_W-1:0] bank_addr,
  output logic                         entry_open,
  output logic                         entry_clear,
  output logic                         check_en,
  output logic [quiz_pkg::QADDR_W-1:0] question_index,
  output logic                         done
);

  quiz_pkg::ctrl_state_t       state;
  // current question
  logic [quiz_pkg::QADDR_W-1:0] q_idx;
  // current question is the final one
  logic                         last_q;
  // result arrived while waiting for it
  logic                         judged;

  assign last_q = (q_idx == quiz_pkg::LAST_QADDR);
  assign judged = (state == quiz_pkg::JUDGE) && result_valid;

  // bank always reads the current question
  // word is stable from the cycle after FETCH on
  assign bank_addr      = q_idx;
  assign question_index = q_idx;

  // keypad live only in ENTRY
  assign entry_open = (state == quiz_pkg::ENTRY);

  // wipe the entry on every judgement
  // blank retries start empty as well
  assign entry_clear = judged;

  // level, held until the next start
  assign done = (state == quiz_pkg::DONE);

  always_ff @(posedge CLK) begin
    if (RST) begin
      state    <= quiz_pkg::IDLE;
      q_idx    <= '0;
      check_en <= 1'b0;
    end else begin
      // single-cycle launch by default
      check_en <= 1'b0;
      case (state)
        quiz_pkg::IDLE,
        quiz_pkg::DONE: begin
          // new game from question 0
          if (start) begin
            q_idx <= '0;
            state <= quiz_pkg::FETCH;
          end
        end
        quiz_pkg::FETCH: begin
          // address out this cycle, word registered at the edge
          state <= quiz_pkg::ENTRY;
        end
        quiz_pkg::ENTRY: begin
          // short entry ignored, player keeps typing
          if (submit && ans_full) begin
            check_en <= 1'b1;
            state    <= quiz_pkg::JUDGE;
          end
        end
        quiz_pkg::JUDGE: begin
          // checker answers two cycles after check_en
          if (result_valid) begin
            if (result.blank) begin
              // same question again
              state <= quiz_pkg::ENTRY;
            end else if (last_q) begin
              state <= quiz_pkg::DONE;
            end else begin
              state <= quiz_pkg::NEXT;
            end
          end
        end
        quiz_pkg::NEXT: begin
          // step to the following question and fetch it
          q_idx <= q_idx + 1'b1;
          state <= quiz_pkg::FETCH;
        end
        default: begin
          state <= quiz_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/quiz_pkg.sv ====
package quiz_pkg;

  // one decimal digit from the keypad
  localparam int DIGIT_W = 4;
  // digits per answer
  localparam int NUM_DIGITS = 3;
  // questions held in the bank
  localparam int NUM_QUESTIONS = 8;
  // bank address width
  localparam int QADDR_W = 3;
  // width of each score counter
  localparam int SCORE_W = 8;
  // prompt code carried in the upper half of a question word
  localparam int PROMPT_W = 12;
  // digit counter in the entry block, counts 0 to 3
  localparam int DCNT_W = 2;

  // count value once all digits are in
  localparam logic [DCNT_W-1:0] DIGITS_FULL = DCNT_W'(NUM_DIGITS);
  // address of the final question
  localparam logic [QADDR_W-1:0] LAST_QADDR = QADDR_W'(NUM_QUESTIONS - 1);

  // three-digit answer, d2 is the first digit keyed in
  typedef struct packed {
    logic [DIGIT_W-1:0] d2;
    logic [DIGIT_W-1:0] d1;
    logic [DIGIT_W-1:0] d0;
  } answer_t;

  // 24-bit question word, prompt on top and key below
  typedef struct packed {
    logic [PROMPT_W-1:0] prompt;
    answer_t             key;
  } question_t;

  // judgement flags, at most one set at a time
  typedef struct packed {
    logic correct;
    logic wrong;
    logic blank;
  } result_t;

  // running score of one game
  typedef struct packed {
    logic [SCORE_W-1:0] n_correct;
    logic [SCORE_W-1:0] n_wrong;
    logic [SCORE_W-1:0] streak;
    logic [SCORE_W-1:0] best_streak;
  } score_t;

  // game sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    ENTRY,
    JUDGE,
    NEXT,
    DONE
  } ctrl_state_t;

endpackage

// ==== logic/quiz_top.sv ====
`timescale 1ns/1ps

module quiz_top (
  input  logic                          CLK,
  input  logic                          RST,
  // bank load, idle only
  input  logic                          load_en,
  input  logic [quiz_pkg::QADDR_W-1:0]  load_addr,
  input  quiz_pkg::question_t           load_data,
  // player controls
  input  logic                          start,
  input  logic                          key_strobe,
  input  logic [quiz_pkg::DIGIT_W-1:0]  key_digit,
  input  logic                          clear_entry,
  input  logic                          submit,
  // game outputs
  output logic [quiz_pkg::PROMPT_W-1:0] prompt,
  output quiz_pkg::result_t             result,
  output logic                          result_valid,
  output quiz_pkg::score_t              score,
  output logic [quiz_pkg::QADDR_W-1:0]  question_index,
  output logic                          done
);

  // bank read path
  logic [quiz_pkg::QADDR_W-1:0] bank_addr;
  quiz_pkg::question_t          q_word;
  // entry block links
  logic                         entry_open;
  logic                         entry_clear;
  logic                         any_clear;
  quiz_pkg::answer_t            ans;
  logic                         ans_full;
  // launch into the checker
  logic                         check_en;

  // prompt of the current question word
  assign prompt = q_word.prompt;

  // player clear or control clear after a judgement
  assign any_clear = clear_entry || entry_clear;

  question_bank i_question_bank (
    .CLK       (CLK),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_addr   (bank_addr),
    .q_word    (q_word)
  );

  answer_entry i_answer_entry (
    .CLK         (CLK),
    .RST         (RST),
    .entry_open  (entry_open),
    .entry_clear (any_clear),
    .key_strobe  (key_strobe),
    .key_digit   (key_digit),
    .ans         (ans),
    .ans_full    (ans_full)
  );

  // key taken from the word already in the bank output register
  answer_check i_answer_check (
    .CLK          (CLK),
    .RST          (RST),
    .check_en     (check_en),
    .ans          (ans),
    .key          (q_word.key),
    .result       (result),
    .result_valid (result_valid)
  );

  quiz_control i_quiz_control (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .submit         (submit),
    .ans_full       (ans_full),
    .result         (result),
    .result_valid   (result_valid),
    .bank_addr      (bank_addr),
    .entry_open     (entry_open),
    .entry_clear    (entry_clear),
    .check_en       (check_en),
    .question_index (question_index),
    .done           (done)
  );

  score_keeper i_score_keeper (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .result       (result),
    .result_valid (result_valid),
    .score        (score)
  );

endmodule

// ==== logic/score_keeper.sv ====
`timescale 1ns/1ps

module score_keeper (
  input  logic              CLK,
  input  logic              RST,
  // new game clears everything
  input  logic              start,
  input  quiz_pkg::result_t result,
  input  logic              result_valid,
  output quiz_pkg::score_t  score
);

  // streak after one more correct answer
  logic [quiz_pkg::SCORE_W-1:0] streak_inc;

  assign streak_inc = score.streak + 1'b1;

  // blank results touch nothing
  // counters cannot wrap with eight questions
  always_ff @(posedge CLK) begin
    if (RST) begin
      score <= '0;
    end else if (start) begin
      score <= '0;
    end else if (result_valid) begin
      if (result.correct) begin
        score.n_correct <= score.n_correct + 1'b1;
        score.streak    <= streak_inc;
        // record follows the streak when it passes the old best
        if (streak_inc > score.best_streak) begin
          score.best_streak <= streak_inc;
        end
      end else if (result.wrong) begin
        score.n_wrong <= score.n_wrong + 1'b1;
        // run broken, best stays
        score.streak  <= '0;
      end
    end
  end

endmodule

// ==== quiz_top.f ====
logic/quiz_pkg.sv
logic/question_bank.sv
logic/answer_entry.sv
logic/answer_check.sv
logic/quiz_control.sv
logic/score_keeper.sv
logic/quiz_top.sv
tb/quiz_tb.sv

// ==== tb/quiz_stim.txt ====
# L addr prompt key : bank load, hex, key digits in entry order
# P keys result : 0-9 keyed, c clear, s early submit, full submit implied; C W B
# S : start pulse, new game from question 0
L 0 a01 123
L 1 a02 456
L 2 a03 789
L 3 a04 305
L 4 a05 999
L 5 a06 100
L 6 a07 042
L 7 a08 870
S
P 123 C
P 000 B
P 466 W
P 78s9 C
P 91c305 C
P 9990 C
P 001 W
P 0s00 B
P 042 C
P 871 W
S
P 123 C
P 456 C

// ==== tb/quiz_tb.sv ====
`timescale 1ns/1ps

module quiz_tb;

  logic                          CLK;
  logic                          RST;
  logic                          load_en;
  logic [quiz_pkg::QADDR_W-1:0]  load_addr;
  quiz_pkg::question_t           load_data;
  logic                          start;
  logic                          key_strobe;
  logic [quiz_pkg::DIGIT_W-1:0]  key_digit;
  logic                          clear_entry;
  logic                          submit;
  logic [quiz_pkg::PROMPT_W-1:0] prompt;
  quiz_pkg::result_t             result;
  logic                          result_valid;
  quiz_pkg::score_t              score;
  logic [quiz_pkg::QADDR_W-1:0]  question_index;
  logic                          done;

  // stim records without the comment lines
  string lines [$];
  // loaded prompts by bank address
  logic [quiz_pkg::PROMPT_W-1:0] exp_prompt [quiz_pkg::NUM_QUESTIONS];
  // reference score and position
  int exp_correct;
  int exp_wrong;
  int exp_streak;
  int exp_best;
  int exp_idx;
  int errors = 0;
  // high between a full submit and its result
  logic awaiting;
  int cycles = 0;
  int cycle_limit = 1000;
  int seed;

  quiz_top i_quiz_top (
    .CLK            (CLK),
    .RST            (RST),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .start          (start),
    .key_strobe     (key_strobe),
    .key_digit      (key_digit),
    .clear_entry    (clear_entry),
    .submit         (submit),
    .prompt         (prompt),
    .result         (result),
    .result_valid   (result_valid),
    .score          (score),
    .question_index (question_index),
    .done           (done)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // run length guard
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // wait one clock and step 1 ns past the edge to sample and drive
  task automatic next_cycle();
    @(posedge CLK);
    #1;
    // a short submit must never be judged
    if (result_valid && !awaiting) begin
      $display("unexpected result_valid at time %0t with no full submit pending", $time);
      errors++;
    end
  endtask

  task automatic check_state(input logic exp_done);
    check_value(32'(score.n_correct), exp_correct, "correct count");
    check_value(32'(score.n_wrong), exp_wrong, "wrong count");
    check_value(32'(score.streak), exp_streak, "streak");
    check_value(32'(score.best_streak), exp_best, "best streak");
    check_value(32'(done), 32'(exp_done), "done");
  endtask

  task automatic check_question();
    check_value(32'(question_index), exp_idx, "question index");
    check_value(32'(prompt), 32'(exp_prompt[exp_idx[quiz_pkg::QADDR_W-1:0]]), "prompt");
  endtask

  task automatic load_question(input int addr, input int prm, input int key);
    load_en          = 1'b1;
    load_addr        = addr[quiz_pkg::QADDR_W-1:0];
    load_data.prompt = prm[quiz_pkg::PROMPT_W-1:0];
    load_data.key    = key[3*quiz_pkg::DIGIT_W-1:0];
    exp_prompt[addr[quiz_pkg::QADDR_W-1:0]] = prm[quiz_pkg::PROMPT_W-1:0];
    next_cycle();
    load_en = 1'b0;
  endtask

  task automatic start_game();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    // prompt valid after FETCH and the bank read
    next_cycle();
    exp_correct = 0;
    exp_wrong   = 0;
    exp_streak  = 0;
    exp_best    = 0;
    exp_idx     = 0;
    check_state(1'b0);
    check_question();
  endtask

  task automatic press_digit(input logic [quiz_pkg::DIGIT_W-1:0] d);
    int gap;
    key_strobe = 1'b1;
    key_digit  = d;
    next_cycle();
    key_strobe = 1'b0;
    // uneven pause between keys
    gap = $random(seed) & 3;
    repeat (gap) next_cycle();
  endtask

  // digits keyed as given, c clears and s submits early
  // the full submit follows the last character
  task automatic play_answer(input string seq, input byte letter);
    byte        ch;
    logic [2:0] exp_flags;
    int         wait_cnt;
    logic       game_over;
    for (int i = 0; i < seq.len(); i++) begin
      ch = seq[i];
      if (ch == "c") begin
        clear_entry = 1'b1;
        next_cycle();
        clear_entry = 1'b0;
      end else if (ch == "s") begin
        submit = 1'b1;
        next_cycle();
        submit = 1'b0;
        repeat (4) next_cycle();
      end else begin
        press_digit(4'(ch - 8'h30));
      end
    end
    // flag order is correct, wrong, blank
    exp_flags = (letter == "C") ? 3'b100 : (letter == "W") ? 3'b010 : 3'b001;
    awaiting = 1'b1;
    submit   = 1'b1;
    next_cycle();
    submit   = 1'b0;
    wait_cnt = 0;
    while (!result_valid && wait_cnt < 8) begin
      next_cycle();
      wait_cnt++;
    end
    awaiting = 1'b0;
    if (!result_valid) begin
      $display("no result_valid within 8 cycles of a full submit, time %0t", $time);
      errors++;
    end else begin
      check_value(32'(result), 32'(exp_flags), "result flags");
    end
    // blank leaves the running totals alone
    if (letter == "C") begin
      exp_correct++;
      exp_streak++;
      if (exp_streak > exp_best) begin
        exp_best = exp_streak;
      end
    end else if (letter == "W") begin
      exp_wrong++;
      exp_streak = 0;
    end
    // score and done follow one cycle later
    next_cycle();
    game_over = (letter != "B") && (exp_idx == quiz_pkg::NUM_QUESTIONS - 1);
    check_state(game_over);
    if (letter == "B") begin
      // entry reopens on the same question
      check_question();
    end else if (!game_over) begin
      // NEXT and FETCH before the new prompt
      repeat (2) next_cycle();
      exp_idx++;
      check_question();
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    addr;
    int    prm;
    int    key;
    int    loads;
    int    plays;
    int    test_no;
    int    tests_failed;
    int    errors_before;
    string line;
    string kind;
    string seq;
    string letter;
    seed         = 32'h65e5bf32;
    RST          = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    start        = 1'b0;
    key_strobe   = 1'b0;
    key_digit    = '0;
    clear_entry  = 1'b0;
    submit       = 1'b0;
    awaiting     = 1'b0;
    loads        = 0;
    plays        = 0;
    test_no      = 0;
    tests_failed = 0;
    // whole file read up front to size the run
    fd = $fopen("tb/quiz_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/quiz_stim.txt for reading");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%s", kind) == 1 && kind[0] != "#") begin
        if (line[line.len()-1] == "\n") begin
          line = line.substr(0, line.len() - 2);
        end
        lines.push_back(line);
        if (kind == "L") begin
          loads++;
        end else begin
          plays++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    cycle_limit = 10 + 2 * loads + 40 * plays + 20;

    repeat (10) next_cycle();
    RST = 1'b0;
    // quiet outputs out of reset
    errors_before = errors;
    exp_correct = 0;
    exp_wrong   = 0;
    exp_streak  = 0;
    exp_best    = 0;
    check_value(32'(result_valid), 0, "result_valid after reset");
    check_state(1'b0);
    test_no++;
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("test %0d [reset] %s", test_no, (errors == errors_before) ? "ok" : "failed");

    foreach (lines[i]) begin
      errors_before = errors;
      n = $sscanf(lines[i], "%s", kind);
      if (kind == "L") begin
        n = $sscanf(lines[i], "%s %h %h %h", kind, addr, prm, key);
        load_question(addr, prm, key);
      end else if (kind == "S") begin
        start_game();
      end else if (kind == "P") begin
        n = $sscanf(lines[i], "%s %s %s", kind, seq, letter);
        play_answer(seq, letter[0]);
      end else begin
        $display("unknown stim record kind %s", kind);
        errors++;
      end
      test_no++;
      if (errors != errors_before) begin
        tests_failed++;
      end
      $display("test %0d [%s] %s", test_no, lines[i],
               (errors == errors_before) ? "ok" : "failed");
    end

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             test_no, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
